// ==== cache_pkg.sv ====
package cache_pkg;

    // word address split: tag | index | offset
    localparam int TAG_W    = 6;
    localparam int INDEX_W  = 2;
    localparam int OFFSET_W = 2;

    // cache geometry
    localparam int NUM_SETS = 4;
    localparam int NUM_WAYS = 2; // one lru bit per set, so two ways only
    localparam int WORD_W   = 32;
    localparam int BLOCK_W  = 128;

    // backing memory
    localparam int BLOCK_ADDR_W = 8; // {tag, index}
    localparam int MEM_BLOCKS   = 256;
    localparam int MEM_LATENCY  = 4;

    // miss handling
    typedef enum logic [1:0] {
        st_idle,
        st_write_back,
        st_allocate
    } ctrl_state_t;

endpackage

// ==== mem_bus_if.sv ====
`timescale 1ns/1ps

// block transfers between controller and main memory
interface mem_bus_if;
    import cache_pkg::*;

    logic                    read;
    logic                    write;
    logic [BLOCK_ADDR_W-1:0] addr;
    logic [BLOCK_W-1:0]      wdata;
    logic [BLOCK_W-1:0]      rdata;
    logic                    ready; // one cycle strobe

    modport ctrl (output read, write, addr, wdata, input rdata, ready);
    modport mem  (input read, write, addr, wdata, output rdata, ready);
endinterface

// lookup and update port of the tag/data store
interface store_if;
    import cache_pkg::*;

    logic [INDEX_W-1:0]  index;
    logic [TAG_W-1:0]    tag;
    logic                hit_write;
    logic [OFFSET_W-1:0] offset;
    logic [WORD_W-1:0]   wdata;
    logic                fill;
    logic [BLOCK_W-1:0]  fill_data;
    logic                fill_dirty;
    logic                touch;

    logic                hit;
    logic                hit_way;
    logic [BLOCK_W-1:0]  hit_block;
    logic                victim_dirty;
    logic [TAG_W-1:0]    victim_tag;
    logic [BLOCK_W-1:0]  victim_block;

    modport ctrl (
        output index, tag, hit_write, offset, wdata, fill, fill_data, fill_dirty, touch,
        input  hit, hit_way, hit_block, victim_dirty, victim_tag, victim_block
    );
    modport store (
        input  index, tag, hit_write, offset, wdata, fill, fill_data, fill_dirty, touch,
        output hit, hit_way, hit_block, victim_dirty, victim_tag, victim_block
    );
endinterface

// ==== cache_store.sv ====
`timescale 1ns/1ps

module cache_store (
    input logic clk,
    input logic proc_reset,
    store_if.store sbus
);
    import cache_pkg::*;

    logic [TAG_W-1:0]   tag_q   [NUM_SETS][NUM_WAYS];
    logic [BLOCK_W-1:0] data_q  [NUM_SETS][NUM_WAYS];
    logic               valid_q [NUM_SETS][NUM_WAYS];
    logic               dirty_q [NUM_SETS][NUM_WAYS];
    logic               lru_q   [NUM_SETS]; // way used most recently

    logic hit0;
    logic hit1;
    logic victim_way;
    logic upd_way;

    // lookup on the current index
    assign hit0 = valid_q[sbus.index][0] && (tag_q[sbus.index][0] == sbus.tag);
    assign hit1 = valid_q[sbus.index][1] && (tag_q[sbus.index][1] == sbus.tag);

    assign sbus.hit       = hit0 || hit1;
    assign sbus.hit_way   = hit1;
    assign sbus.hit_block = data_q[sbus.index][sbus.hit_way];

    assign victim_way = ~lru_q[sbus.index];

    assign sbus.victim_dirty = valid_q[sbus.index][victim_way] &&
                               dirty_q[sbus.index][victim_way];
    assign sbus.victim_tag   = tag_q[sbus.index][victim_way];
    assign sbus.victim_block = data_q[sbus.index][victim_way];

    // way that becomes most recent after this access
    assign upd_way = sbus.fill ? victim_way : sbus.hit_way;

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            lru_q   <= '{default: '0};
        end else begin
            if (sbus.fill) begin
                valid_q[sbus.index][victim_way] <= 1'b1;
                dirty_q[sbus.index][victim_way] <= sbus.fill_dirty;
            end else if (sbus.hit_write && sbus.hit) begin
                dirty_q[sbus.index][sbus.hit_way] <= 1'b1;
            end
            if (sbus.fill || sbus.touch)
                lru_q[sbus.index] <= upd_way;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (sbus.fill) begin
            tag_q[sbus.index][victim_way]  <= sbus.tag;
            data_q[sbus.index][victim_way] <= sbus.fill_data;
        end else if (sbus.hit_write && sbus.hit) begin
            data_q[sbus.index][sbus.hit_way][sbus.offset*WORD_W +: WORD_W] <= sbus.wdata;
        end
    end

    // fills always go to the way that does not match, so a tag lives in one way only
    a_single_hit: assert property (
        @(posedge clk) disable iff (proc_reset) !(hit0 && hit1)
    ) else $error("tag %0h present in both ways of set %0d", sbus.tag, sbus.index);

endmodule

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                        clk,
    input  logic                        proc_reset,
    input  logic                        proc_read,
    input  logic                        proc_write,
    input  logic [29:0]                 proc_addr,
    input  logic [cache_pkg::WORD_W-1:0] proc_wdata,
    output logic [cache_pkg::WORD_W-1:0] proc_rdata,
    output logic                        proc_stall,
    store_if.ctrl                       sbus,
    mem_bus_if.ctrl                     mbus
);
    import cache_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
    logic                req;
    logic                idle_hit;
    logic [BLOCK_W-1:0]  src_block;
    logic [BLOCK_W-1:0]  merged;

    // upper address bits are ignored
    assign tag    = proc_addr[OFFSET_W+INDEX_W +: TAG_W];
    assign index  = proc_addr[OFFSET_W +: INDEX_W];
    assign offset = proc_addr[OFFSET_W-1:0];

    assign req      = proc_read || proc_write;
    assign idle_hit = (state_q == st_idle) && req && sbus.hit;

    // lookup side
    assign sbus.index     = index;
    assign sbus.tag       = tag;
    assign sbus.offset    = offset;
    assign sbus.wdata     = proc_wdata;
    assign sbus.hit_write = idle_hit && proc_write;
    assign sbus.touch     = idle_hit;

    // fetched block with the processor word merged in on a write miss
    always_comb begin
        merged = mbus.rdata;
        if (proc_write)
            merged[offset*WORD_W +: WORD_W] = proc_wdata;
    end

    assign sbus.fill       = (state_q == st_allocate) && mbus.ready;
    assign sbus.fill_data  = merged;
    assign sbus.fill_dirty = proc_write;

    // memory side
    assign mbus.read  = (state_q == st_allocate);
    assign mbus.write = (state_q == st_write_back);
    assign mbus.addr  = (state_q == st_write_back) ? {sbus.victim_tag, index} : {tag, index};
    assign mbus.wdata = sbus.victim_block;

    // hit word, or forwarded from memory at the end of a miss
    assign src_block  = (state_q == st_allocate) ? mbus.rdata : sbus.hit_block;
    assign proc_rdata = src_block[offset*WORD_W +: WORD_W];

    always_comb begin
        state_d    = state_q;
        proc_stall = 1'b0;
        case (state_q)
            st_idle: begin
                if (req && !sbus.hit) begin
                    proc_stall = 1'b1;
                    state_d    = sbus.victim_dirty ? st_write_back : st_allocate;
                end
            end
            st_write_back: begin
                proc_stall = 1'b1;
                if (mbus.ready)
                    state_d = st_allocate;
            end
            st_allocate: begin
                proc_stall = !mbus.ready; // released with the fill
                if (mbus.ready)
                    state_d = st_idle;
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset)
            state_q <= st_idle;
        else
            state_q <= state_d;
    end

    // the stalled request must stay put until the miss is done
    a_req_held_in_miss: assert property (
        @(posedge clk) disable iff (proc_reset)
        (state_q != st_idle) |-> req && $stable(proc_write) && $stable(proc_addr)
    ) else $error("processor request changed during %s", state_q.name());

endmodule

// ==== main_memory.sv ====
`timescale 1ns/1ps

module main_memory (
    input logic clk,
    input logic proc_reset,
    mem_bus_if.mem mbus
);
    import cache_pkg::*;

    logic [BLOCK_W-1:0] mem_q [MEM_BLOCKS];

    logic [$clog2(MEM_LATENCY+1)-1:0] count_q; // cycles the request has been waiting
    logic req;

    // power-up content: every word holds its own word address
    initial begin
        int b;
        int w;
        for (b = 0; b < MEM_BLOCKS; b++) begin
            for (w = 0; w < BLOCK_W/WORD_W; w++)
                mem_q[b][w*WORD_W +: WORD_W] = WORD_W'(b * (BLOCK_W/WORD_W) + w);
        end
    end

    assign req = mbus.read || mbus.write;

    assign mbus.ready = req && (count_q == MEM_LATENCY);
    assign mbus.rdata = mem_q[mbus.addr];

    always_ff @(posedge clk) begin
        if (proc_reset)
            count_q <= '0;
        else if (mbus.ready)
            count_q <= '0;
        else if (req)
            count_q <= count_q + 1'b1;
    end

    // write commits with the ready strobe
    always @(posedge clk) begin
        if (mbus.write && mbus.ready)
            mem_q[mbus.addr] <= mbus.wdata;
    end

    // one request at a time, held unchanged until ready
    a_req_held: assert property (
        @(posedge clk) disable iff (proc_reset)
        req && !mbus.ready |=> $stable(mbus.read) && $stable(mbus.write) &&
                               $stable(mbus.addr) && (!mbus.write || $stable(mbus.wdata))
    ) else $error("memory request changed before ready, addr %0h", mbus.addr);

endmodule

// ==== cache_system.sv ====
`timescale 1ns/1ps

module cache_system (
    input  logic                        clk,
    input  logic                        proc_reset,
    input  logic                        proc_read,
    input  logic                        proc_write,
    input  logic [29:0]                 proc_addr,
    input  logic [cache_pkg::WORD_W-1:0] proc_wdata,
    output logic [cache_pkg::WORD_W-1:0] proc_rdata,
    output logic                        proc_stall
);

    mem_bus_if mbus ();
    store_if   sbus ();

    cache_ctrl ctrl_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .sbus       (sbus.ctrl),
        .mbus       (mbus.ctrl)
    );

    cache_store store_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .sbus       (sbus.store)
    );

    main_memory mem_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .mbus       (mbus.mem)
    );

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic proc_reset
);
    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 5;

    initial clk = 1'b0;
    always #(PERIOD_NS / 2) clk = ~clk;

    initial begin
        proc_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        proc_reset <= 1'b0;
    end

endmodule

// ==== cache_checker.sv ====
`timescale 1ns/1ps

module cache_checker (
    input logic                         clk,
    input logic                         proc_reset,
    input logic                         proc_read,
    input logic                         proc_write,
    input logic [29:0]                  proc_addr,
    input logic [cache_pkg::WORD_W-1:0] proc_wdata,
    input logic [cache_pkg::WORD_W-1:0] proc_rdata,
    input logic                         proc_stall
);
    import cache_pkg::*;

    logic [WORD_W-1:0] shadow [1024]; // every word the processor can see
    logic [TAG_W-1:0]  ref_tag [NUM_SETS][NUM_WAYS];
    logic              ref_valid [NUM_SETS][NUM_WAYS];
    logic              ref_lru [NUM_SETS]; // most recent way
    logic              stalled;           // current request has seen a stall

    string test_name;
    int    test_checks;
    int    test_errors;
    int    total_checks;
    int    total_errors;
    int    tests_run;
    int    tests_failed;

    initial begin
        for (int a = 0; a < 1024; a++)
            shadow[a] = WORD_W'(a);
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
        stalled      = 1'b0;
        test_name    = "none";
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
    end

    // expected word for a read of this address
    function automatic logic [WORD_W-1:0] expected_word(input logic [9:0] addr);
        return shadow[addr];
    endfunction

    // way holding the tag, -1 on a miss
    function automatic int find_way(input logic [TAG_W-1:0] tag, input logic [INDEX_W-1:0] set);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag)
                return w;
        end
        return -1;
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        test_checks++;
        if (exp !== act) begin
            test_errors++;
            $display("error %s %s: expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic retire(input logic hit_seen);
        logic [9:0]         addr;
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] set;
        int                 way;
        addr = proc_addr[9:0];
        tag  = addr[OFFSET_W+INDEX_W +: TAG_W];
        set  = addr[OFFSET_W +: INDEX_W];
        way  = find_way(tag, set);
        compare($sformatf("hit %03h", addr), 32'(way >= 0), 32'(hit_seen));
        if (proc_read)
            compare($sformatf("read %03h", addr), expected_word(addr), proc_rdata);
        else
            shadow[addr] = proc_wdata;
        if (way < 0) begin
            way = ref_lru[set] ? 0 : 1; // the way not used most recently
            ref_tag[set][way]   = tag;
            ref_valid[set][way] = 1'b1;
        end
        ref_lru[set] = way[0];
    endtask

    // a request retires at the edge where stall is low
    always @(posedge clk) begin
        if (!proc_reset && (proc_read || proc_write)) begin
            if (proc_stall) begin
                stalled = 1'b1;
            end else begin
                retire(!stalled);
                stalled = 1'b0;
            end
        end
    end

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_checks += test_checks;
        total_errors += test_errors;
        if (test_errors != 0)
            tests_failed++;
        $display("%-12s %s  %0d checks, %0d errors", test_name,
                 (test_errors == 0) ? "ok" : "FAILED", test_checks, test_errors);
    endtask

    task automatic report();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, total_checks, total_errors);
    endtask

endmodule

// ==== cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;
    import cache_pkg::*;

    localparam int MAX_REQUESTS   = 300;
    localparam int REQ_CYCLES     = 2 * (MEM_LATENCY + 2) + 2; // dirty miss, worst case
    localparam int TIMEOUT_CYCLES = MAX_REQUESTS * REQ_CYCLES + 800;

    logic              clk;
    logic              proc_reset;
    logic              proc_read;
    logic              proc_write;
    logic [29:0]       proc_addr;
    logic [WORD_W-1:0] proc_wdata;
    logic [WORD_W-1:0] proc_rdata;
    logic              proc_stall;

    integer seed;
    int     cycles = 0;

    tb_clock clock_i (
        .clk        (clk),
        .proc_reset (proc_reset)
    );

    cache_system cache_system_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall)
    );

    cache_checker checker_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall)
    );

    // present one request and hold it until the edge where it retires
    task automatic access(input logic wr, input logic [9:0] addr, input logic [31:0] data);
        logic stalled;
        proc_read  <= !wr;
        proc_write <= wr;
        proc_addr  <= {20'h0, addr}; // upper bits unused by the cache
        proc_wdata <= data;
        do begin
            @(negedge clk);
            stalled = proc_stall;
            @(posedge clk);
        end while (stalled);
    endtask

    task automatic read_word(input logic [9:0] addr);
        access(1'b0, addr, 32'h0);
    endtask

    task automatic write_word(input logic [9:0] addr, input logic [31:0] data);
        access(1'b1, addr, data);
    endtask

    // idle one cycle so the checker has seen the last retire
    task automatic close_test();
        proc_read  <= 1'b0;
        proc_write <= 1'b0;
        @(posedge clk);
        checker_i.end_test();
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT never released its stall", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        logic [31:0] rnd;
        logic [9:0]  addr;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        seed       = 32'h3a32;
        @(negedge proc_reset);
        @(posedge clk);

        checker_i.begin_test("cold_read");
        read_word(10'h000);
        read_word(10'h015);
        read_word(10'h2a3);
        read_word(10'h015);
        close_test();

        checker_i.begin_test("write_hit");
        read_word(10'h040);
        write_word(10'h041, 32'hcafe_0041);
        read_word(10'h041);
        read_word(10'h040);
        read_word(10'h042);
        read_word(10'h043);
        close_test();

        checker_i.begin_test("write_miss");
        write_word(10'h105, 32'h1234_5678);
        read_word(10'h104);
        read_word(10'h106);
        read_word(10'h107);
        read_word(10'h105);
        close_test();

        // tags 5, 6, 7 all in set 2
        checker_i.begin_test("dirty_evict");
        write_word(10'h059, 32'h5555_0001);
        write_word(10'h069, 32'h6666_0001);
        write_word(10'h079, 32'h7777_0001);
        read_word(10'h059);
        read_word(10'h058);
        close_test();

        // A, B, A, C in set 3 then A hits and B misses
        checker_i.begin_test("lru_order");
        read_word(10'h08c);
        read_word(10'h09c);
        read_word(10'h08c);
        read_word(10'h0ac);
        read_word(10'h08c);
        read_word(10'h09c);
        close_test();

        // 32 words: tags 0..3, sets 0..1, all offsets
        checker_i.begin_test("random");
        for (int i = 0; i < 200; i++) begin
            rnd  = $random(seed);
            addr = {4'b0000, rnd[4:3], 1'b0, rnd[2:0]};
            if (rnd[8])
                write_word(addr, $random(seed));
            else
                read_word(addr);
        end
        close_test();

        checker_i.report();
        if (checker_i.total_errors == 0 && checker_i.total_checks > 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== list.f ====
cache_pkg.sv
mem_bus_if.sv
cache_store.sv
cache_ctrl.sv
main_memory.sv
cache_system.sv
tb_clock.sv
cache_checker.sv
cache_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = cache_tb
RTL_TOP    = cache_system
FILELIST   = list.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
PASS_MSG   = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
